// File: codec_pkg.sv
package codec_pkg;

    localparam int FRAME_BITS = 128;
    localparam int CODED_BITS = 384;
    localparam int SYM_PAIR_W = 6;
    localparam int NUM_STEPS  = 128;
    localparam int NUM_STATES = 4;
    localparam int DATA_W     = 32;

    localparam int ENC_WORDS   = FRAME_BITS / DATA_W;   // 4
    localparam int CODED_WORDS = CODED_BITS / DATA_W;   // 12

    typedef logic [FRAME_BITS-1:0] frame_t;
    typedef logic [CODED_BITS-1:0] coded_frame_t;
    typedef logic [SYM_PAIR_W-1:0] sym_pair_t;
    typedef logic [9:0]            metric_t;
    typedef logic [7:0]            axil_addr_t;
    typedef logic [DATA_W-1:0]     axil_data_t;

    localparam logic MODE_ENCODE = 1'b0;
    localparam logic MODE_DECODE = 1'b1;
    localparam logic RATE_HALF   = 1'b0;
    localparam logic RATE_THIRD  = 1'b1;

    localparam axil_addr_t REG_CTRL     = 8'h00;
    localparam axil_addr_t REG_STATUS   = 8'h04;
    localparam axil_addr_t REG_ENC_BASE = 8'h10;
    localparam axil_addr_t REG_DEC_BASE = 8'h20;
    localparam axil_addr_t REG_RES_BASE = 8'h50;

    // Start value for every state except 0 where the encoder begins
    localparam metric_t METRIC_UNREACHED = 10'd512;

endpackage

// File: axil_regs.sv
`timescale 1ns/1ps

module axil_regs
    import codec_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  axil_addr_t   i_awaddr,
    input  logic         i_awvalid,
    output logic         o_awready,
    input  axil_data_t   i_wdata,
    input  logic         i_wvalid,
    output logic         o_wready,
    output logic [1:0]   o_bresp,
    output logic         o_bvalid,
    input  logic         i_bready,
    input  axil_addr_t   i_araddr,
    input  logic         i_arvalid,
    output logic         o_arready,
    output axil_data_t   o_rdata,
    output logic [1:0]   o_rresp,
    output logic         o_rvalid,
    input  logic         i_rready,
    input  logic         i_enc_done,
    input  coded_frame_t i_coded,
    input  logic         i_dec_done,
    input  frame_t       i_decoded,
    output logic         o_start,
    output logic         o_mode,
    output logic         o_rate,
    output frame_t       o_enc_frame,
    output coded_frame_t o_dec_frame
);

typedef enum logic [1:0] {WR_IDLE, WR_ACCEPT, WR_EXEC, WR_RESP} wr_state_t;

wr_state_t    wr_state;
axil_addr_t   awaddr_q;
axil_data_t   wdata_q;
axil_addr_t   wr_enc_idx;
axil_addr_t   wr_dec_idx;
axil_addr_t   rd_enc_idx;
axil_addr_t   rd_dec_idx;
axil_addr_t   rd_res_idx;
axil_data_t   rd_data;
coded_frame_t result;
logic         busy;
logic         done;

function automatic axil_addr_t word_index(input axil_addr_t addr, input axil_addr_t base);
    return (addr - base) >> 2;   // Wraps high below base, so one compare covers the range
endfunction

assign o_bresp = 2'b00;
assign o_rresp = 2'b00;

assign wr_enc_idx = word_index(awaddr_q, REG_ENC_BASE);
assign wr_dec_idx = word_index(awaddr_q, REG_DEC_BASE);

always_ff @(posedge clk)
begin
    if (!rst)
    begin
        wr_state  <= WR_IDLE;
        o_awready <= 1'b0;
        o_wready  <= 1'b0;
        o_bvalid  <= 1'b0;
        o_start   <= 1'b0;
        o_mode    <= MODE_ENCODE;
        o_rate    <= RATE_HALF;
        busy      <= 1'b0;
        done      <= 1'b0;
    end
    else
    begin
        o_start <= 1'b0;
        case (wr_state)
            WR_IDLE:
            begin
                o_awready <= 1'b1;
                o_wready  <= 1'b1;
                wr_state  <= WR_ACCEPT;
            end
            WR_ACCEPT:
            begin
                if (i_awvalid && o_awready)
                    o_awready <= 1'b0;
                if (i_wvalid && o_wready)
                    o_wready <= 1'b0;
                if (!o_awready && !o_wready)
                    wr_state <= WR_EXEC;
            end
            WR_EXEC:
            begin
                if (awaddr_q == REG_CTRL && !busy)
                begin
                    o_mode <= wdata_q[1];
                    o_rate <= wdata_q[2];
                    if (wdata_q[0])
                    begin
                        o_start <= 1'b1;
                        busy    <= 1'b1;
                        done    <= 1'b0;
                    end
                end
                o_bvalid <= 1'b1;
                wr_state <= WR_RESP;
            end
            WR_RESP:
            begin
                if (i_bready)
                begin
                    o_bvalid <= 1'b0;
                    wr_state <= WR_IDLE;
                end
            end
            default: wr_state <= WR_IDLE;
        endcase

        if (i_enc_done || i_dec_done)
        begin
            busy <= 1'b0;
            done <= 1'b1;
        end
    end
end

always_ff @(posedge clk)
begin
    if (wr_state == WR_ACCEPT && i_awvalid && o_awready)
        awaddr_q <= i_awaddr;
    if (wr_state == WR_ACCEPT && i_wvalid && o_wready)
        wdata_q <= i_wdata;

    if (wr_state == WR_EXEC && !busy)
    begin
        if (wr_enc_idx < ENC_WORDS)
            o_enc_frame[DATA_W*wr_enc_idx +: DATA_W] <= wdata_q;
        if (wr_dec_idx < CODED_WORDS)
            o_dec_frame[DATA_W*wr_dec_idx +: DATA_W] <= wdata_q;
    end

    if (i_enc_done || i_dec_done)
        result <= (o_mode == MODE_DECODE) ? coded_frame_t'(i_decoded) : i_coded;
end

always_comb
begin
    rd_enc_idx = word_index(i_araddr, REG_ENC_BASE);
    rd_dec_idx = word_index(i_araddr, REG_DEC_BASE);
    rd_res_idx = word_index(i_araddr, REG_RES_BASE);
    rd_data    = '0;
    if (i_araddr == REG_CTRL)
        rd_data = {29'd0, o_rate, o_mode, 1'b0};
    else if (i_araddr == REG_STATUS)
        rd_data = {30'd0, done, busy};
    else if (rd_enc_idx < ENC_WORDS)
        rd_data = o_enc_frame[DATA_W*rd_enc_idx +: DATA_W];
    else if (rd_dec_idx < CODED_WORDS)
        rd_data = o_dec_frame[DATA_W*rd_dec_idx +: DATA_W];
    else if (rd_res_idx < CODED_WORDS)
        rd_data = result[DATA_W*rd_res_idx +: DATA_W];
end

always_ff @(posedge clk)
begin
    if (!rst)
    begin
        o_arready <= 1'b0;
        o_rvalid  <= 1'b0;
    end
    else if (o_arready && i_arvalid)
    begin
        o_arready <= 1'b0;
        o_rvalid  <= 1'b1;
    end
    else if (o_rvalid && i_rready)
    begin
        o_rvalid  <= 1'b0;
        o_arready <= 1'b1;
    end
    else if (!o_rvalid)
        o_arready <= 1'b1;
end

always_ff @(posedge clk)
begin
    if (o_arready && i_arvalid)
        o_rdata <= rd_data;
end

endmodule

// File: frame_slicer.sv
`timescale 1ns/1ps

module frame_slicer
    import codec_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         i_start,
    input  logic         i_mode,
    input  logic         i_rate,
    input  frame_t       i_enc_frame,
    input  coded_frame_t i_dec_frame,
    output logic         o_bit_valid,
    output logic         o_tx_bit,
    output logic         o_sym_valid,
    output sym_pair_t    o_rx_syms,
    output logic         o_last
);

logic       running;
logic [6:0] tx_idx;
logic [8:0] rx_idx;
logic       last_item;
sym_pair_t  syms;

always_comb
begin
    // Slot bit 0 takes the highest frame index and so the g0 output
    if (i_rate == RATE_THIRD)
    begin
        syms = {i_dec_frame[rx_idx - 5], i_dec_frame[rx_idx - 4], i_dec_frame[rx_idx - 3],
                i_dec_frame[rx_idx - 2], i_dec_frame[rx_idx - 1], i_dec_frame[rx_idx]};
        last_item = (rx_idx == 9'd5);
    end
    else
    begin
        syms = {1'b0, i_dec_frame[rx_idx - 3], i_dec_frame[rx_idx - 2],
                1'b0, i_dec_frame[rx_idx - 1], i_dec_frame[rx_idx]};
        last_item = (rx_idx == 9'd3);
    end
    if (i_mode == MODE_ENCODE)
        last_item = (tx_idx == 7'd0);
end

assign o_bit_valid = running && (i_mode == MODE_ENCODE);
assign o_sym_valid = running && (i_mode == MODE_DECODE);
assign o_tx_bit    = o_bit_valid ? i_enc_frame[tx_idx] : 1'b0;
assign o_rx_syms   = o_sym_valid ? syms : '0;
assign o_last      = running && last_item;

always_ff @(posedge clk)
begin
    if (!rst)
    begin
        running <= 1'b0;
        tx_idx  <= '0;
        rx_idx  <= '0;
    end
    else if (i_start)
    begin
        running <= 1'b1;
        tx_idx  <= 7'(FRAME_BITS - 1);
        rx_idx  <= (i_rate == RATE_HALF) ? 9'(2*FRAME_BITS - 1) : 9'(CODED_BITS - 1);
    end
    else if (running)
    begin
        if (last_item)
            running <= 1'b0;   // Stop after the final item
        if (i_mode == MODE_ENCODE)
            tx_idx <= tx_idx - 7'd1;
        else
            rx_idx <= rx_idx - ((i_rate == RATE_THIRD) ? 9'd6 : 9'd4);
    end
end

endmodule

// File: conv_encoder.sv
`timescale 1ns/1ps

module conv_encoder
    import codec_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         i_start,
    input  logic         i_rate,
    input  logic         i_bit_valid,
    input  logic         i_tx_bit,
    input  logic         i_last,
    output coded_frame_t o_coded,
    output logic         o_done
);

logic [1:0] sr;    // Previous bit in [1], the one before in [0]
logic [8:0] ptr;   // Index of the next g0 output
logic       g0;
logic       g1;
logic       g2;

always_comb
begin
    g0 = i_tx_bit ^ sr[1] ^ sr[0];                            // 7
    g1 = (i_rate == RATE_THIRD) ? g0 : (i_tx_bit ^ sr[0]);   // 7 or 5
    g2 = i_tx_bit ^ sr[0];                                    // 5
end

always_ff @(posedge clk)
begin
    if (!rst)
    begin
        sr     <= '0;
        ptr    <= '0;
        o_done <= 1'b0;
    end
    else
    begin
        o_done <= i_bit_valid && i_last;
        if (i_start)
        begin
            sr  <= '0;
            ptr <= (i_rate == RATE_THIRD) ? 9'(CODED_BITS - 1) : 9'(2*FRAME_BITS - 1);
        end
        else if (i_bit_valid)
        begin
            sr  <= {i_tx_bit, sr[1]};
            ptr <= ptr - ((i_rate == RATE_THIRD) ? 9'd3 : 9'd2);
        end
    end
end

always_ff @(posedge clk)
begin
    if (i_start)
        o_coded <= '0;
    else if (i_bit_valid)
    begin
        o_coded[ptr]     <= g0;
        o_coded[ptr - 1] <= g1;
        if (i_rate == RATE_THIRD)
            o_coded[ptr - 2] <= g2;
    end
end

endmodule

// File: viterbi_decoder.sv
`timescale 1ns/1ps

module viterbi_decoder
    import codec_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      i_start,
    input  logic      i_rate,
    input  logic      i_sym_valid,
    input  sym_pair_t i_rx_syms,
    input  logic      i_last,
    output frame_t    o_decoded,
    output logic      o_done
);

typedef enum logic [1:0] {ST_IDLE, ST_ACS, ST_SELECT, ST_TRACE} vit_state_t;

vit_state_t                     state;
metric_t [NUM_STATES-1:0]       pm;
metric_t [NUM_STATES-1:0]       pm_mid;
metric_t [NUM_STATES-1:0]       pm_next;
logic [NUM_STATES-1:0]          dec_a;
logic [NUM_STATES-1:0]          dec_b;
logic [NUM_STATES-1:0]          surv [NUM_STEPS];
logic [$clog2(NUM_STEPS)-1:0]   step;
logic [1:0]                     tb_state;
logic [1:0]                     best_state;

// Hamming distance from the received symbol to the branch p -> {u, p[1]}
function automatic logic [1:0] branch_metric(
    input logic [1:0] p,
    input logic       u,
    input logic [2:0] r,
    input logic       rate
);
    logic [2:0] expect_sym;
    logic [2:0] diff;
    expect_sym[0] = u ^ p[1] ^ p[0];
    expect_sym[1] = (rate == RATE_THIRD) ? (u ^ p[1] ^ p[0]) : (u ^ p[0]);
    expect_sym[2] = u ^ p[0];
    diff = expect_sym ^ r;
    if (rate == RATE_HALF)
        diff[2] = 1'b0;
    return {1'b0, diff[0]} + {1'b0, diff[1]} + {1'b0, diff[2]};
endfunction

function automatic void acs_step(
    input  metric_t [NUM_STATES-1:0] pm_in,
    input  logic [2:0]               sym,
    input  logic                     rate,
    output metric_t [NUM_STATES-1:0] pm_out,
    output logic [NUM_STATES-1:0]    dec
);
    logic [1:0] p0;
    logic [1:0] p1;
    metric_t    m0;
    metric_t    m1;
    for (int s = 0; s < NUM_STATES; s++)
    begin
        p0 = {s[0], 1'b0};   // Both predecessors share s[0] as their newest bit
        p1 = {s[0], 1'b1};
        m0 = pm_in[p0] + branch_metric(p0, s[1], sym, rate);
        m1 = pm_in[p1] + branch_metric(p1, s[1], sym, rate);
        dec[s]    = (m1 < m0);
        pm_out[s] = (m1 < m0) ? m1 : m0;
    end
endfunction

always_comb
begin
    acs_step(pm, i_rx_syms[2:0], i_rate, pm_mid, dec_a);
    acs_step(pm_mid, i_rx_syms[5:3], i_rate, pm_next, dec_b);
end

always_comb
begin
    best_state = 2'd0;
    for (int s = 1; s < NUM_STATES; s++)
    begin
        if (pm[s] < pm[best_state])   // Strict compare keeps the lower index on a tie
            best_state = 2'(s);
    end
end

always_ff @(posedge clk)
begin
    if (!rst)
    begin
        state  <= ST_IDLE;
        step   <= '0;
        o_done <= 1'b0;
    end
    else
    begin
        o_done <= 1'b0;
        if (i_start)
        begin
            state <= ST_ACS;
            step  <= '0;
        end
        else
        begin
            case (state)
                ST_ACS:
                begin
                    if (i_sym_valid)
                    begin
                        step <= step + 2'd2;
                        if (i_last)
                            state <= ST_SELECT;
                    end
                end
                ST_SELECT:
                begin
                    step  <= '1;
                    state <= ST_TRACE;
                end
                ST_TRACE:
                begin
                    step <= step - 1'b1;
                    if (step == '0)
                    begin
                        state  <= ST_IDLE;
                        o_done <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end
end

always_ff @(posedge clk)
begin
    if (i_start)
    begin
        for (int s = 0; s < NUM_STATES; s++)
            pm[s] <= (s == 0) ? metric_t'(0) : METRIC_UNREACHED;
    end
    else if (state == ST_ACS && i_sym_valid)
        pm <= pm_next;

    if (state == ST_ACS && i_sym_valid)
    begin
        surv[step]        <= dec_a;
        surv[step + 1'b1] <= dec_b;
    end

    if (state == ST_SELECT)
        tb_state <= best_state;
    else if (state == ST_TRACE)
        tb_state <= {tb_state[0], surv[step][tb_state]};

    // Step 127 is the last bit sent, which is frame bit 0
    if (state == ST_TRACE)
        o_decoded[~step] <= tb_state[1];
end

endmodule

// File: conv_codec.sv
`timescale 1ns/1ps

module conv_codec
    import codec_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  axil_addr_t i_s_axil_awaddr,
    input  logic       i_s_axil_awvalid,
    output logic       o_s_axil_awready,
    input  axil_data_t i_s_axil_wdata,
    input  logic       i_s_axil_wvalid,
    output logic       o_s_axil_wready,
    output logic [1:0] o_s_axil_bresp,
    output logic       o_s_axil_bvalid,
    input  logic       i_s_axil_bready,
    input  axil_addr_t i_s_axil_araddr,
    input  logic       i_s_axil_arvalid,
    output logic       o_s_axil_arready,
    output axil_data_t o_s_axil_rdata,
    output logic [1:0] o_s_axil_rresp,
    output logic       o_s_axil_rvalid,
    input  logic       i_s_axil_rready
);

logic         start;
logic         mode;
logic         rate;
frame_t       enc_frame;
coded_frame_t dec_frame;
logic         bit_valid;
logic         tx_bit;
logic         sym_valid;
sym_pair_t    rx_syms;
logic         last;
coded_frame_t coded;
logic         enc_done;
frame_t       decoded;
logic         dec_done;

axil_regs regs_i (
    .clk         (clk),
    .rst         (rst),
    .i_awaddr    (i_s_axil_awaddr),
    .i_awvalid   (i_s_axil_awvalid),
    .o_awready   (o_s_axil_awready),
    .i_wdata     (i_s_axil_wdata),
    .i_wvalid    (i_s_axil_wvalid),
    .o_wready    (o_s_axil_wready),
    .o_bresp     (o_s_axil_bresp),
    .o_bvalid    (o_s_axil_bvalid),
    .i_bready    (i_s_axil_bready),
    .i_araddr    (i_s_axil_araddr),
    .i_arvalid   (i_s_axil_arvalid),
    .o_arready   (o_s_axil_arready),
    .o_rdata     (o_s_axil_rdata),
    .o_rresp     (o_s_axil_rresp),
    .o_rvalid    (o_s_axil_rvalid),
    .i_rready    (i_s_axil_rready),
    .i_enc_done  (enc_done),
    .i_coded     (coded),
    .i_dec_done  (dec_done),
    .i_decoded   (decoded),
    .o_start     (start),
    .o_mode      (mode),
    .o_rate      (rate),
    .o_enc_frame (enc_frame),
    .o_dec_frame (dec_frame)
);

frame_slicer slicer_i (
    .clk         (clk),
    .rst         (rst),
    .i_start     (start),
    .i_mode      (mode),
    .i_rate      (rate),
    .i_enc_frame (enc_frame),
    .i_dec_frame (dec_frame),
    .o_bit_valid (bit_valid),
    .o_tx_bit    (tx_bit),
    .o_sym_valid (sym_valid),
    .o_rx_syms   (rx_syms),
    .o_last      (last)
);

conv_encoder encoder_i (
    .clk         (clk),
    .rst         (rst),
    .i_start     (start),
    .i_rate      (rate),
    .i_bit_valid (bit_valid),
    .i_tx_bit    (tx_bit),
    .i_last      (last),
    .o_coded     (coded),
    .o_done      (enc_done)
);

viterbi_decoder decoder_i (
    .clk         (clk),
    .rst         (rst),
    .i_start     (start),
    .i_rate      (rate),
    .i_sym_valid (sym_valid),
    .i_rx_syms   (rx_syms),
    .i_last      (last),
    .o_decoded   (decoded),
    .o_done      (dec_done)
);

endmodule

// File: tb_conv_codec.sv
`timescale 1ns/1ps

module tb_conv_codec
    import codec_pkg::*;
();

localparam int TIMEOUT_CYCLES = 64;
localparam int POLL_LIMIT     = 200;

logic       clk;
logic       rst;
axil_addr_t awaddr;
logic       awvalid;
logic       awready;
axil_data_t wdata;
logic       wvalid;
logic       wready;
logic [1:0] bresp;
logic       bvalid;
logic       bready;
axil_addr_t araddr;
logic       arvalid;
logic       arready;
axil_data_t rdata;
logic [1:0] rresp;
logic       rvalid;
logic       rready;

int errors;
int err_at_start;
int tests_run;
int tests_failing;

conv_codec dut_i (
    .clk              (clk),
    .rst              (rst),
    .i_s_axil_awaddr  (awaddr),
    .i_s_axil_awvalid (awvalid),
    .o_s_axil_awready (awready),
    .i_s_axil_wdata   (wdata),
    .i_s_axil_wvalid  (wvalid),
    .o_s_axil_wready  (wready),
    .o_s_axil_bresp   (bresp),
    .o_s_axil_bvalid  (bvalid),
    .i_s_axil_bready  (bready),
    .i_s_axil_araddr  (araddr),
    .i_s_axil_arvalid (arvalid),
    .o_s_axil_arready (arready),
    .o_s_axil_rdata   (rdata),
    .o_s_axil_rresp   (rresp),
    .o_s_axil_rvalid  (rvalid),
    .i_s_axil_rready  (rready)
);

initial
begin
    clk = 1'b0;
    forever #20 clk = ~clk;
end

task automatic abort_run(input string what);
    $display("Timeout at %0t ns, %s never completed", $time, what);
    $display("Testbench failed");
    $finish;
endtask

task automatic report_mismatch(input string what, input axil_data_t got, input axil_data_t exp);
    errors++;
    $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
endtask

task automatic begin_test();
    err_at_start = errors;
    tests_run++;
endtask

task automatic end_test(input string name);
    if (errors == err_at_start)
        $display("%s: ok", name);
    else
    begin
        tests_failing++;
        $display("%s: %0d errors", name, errors - err_at_start);
    end
endtask

task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
    bit aw_done;
    bit w_done;
    bit aw_hs;
    bit w_hs;
    int cycles;
    aw_done = 1'b0;
    w_done  = 1'b0;
    cycles  = 0;
    @(negedge clk);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wvalid  = 1'b1;
    bready  = 1'b1;
    while (!(aw_done && w_done))
    begin
        aw_hs = awvalid && awready;   // Ready seen here holds through the next rising edge
        w_hs  = wvalid && wready;
        @(negedge clk);
        if (aw_hs)
        begin
            awvalid = 1'b0;
            aw_done = 1'b1;
        end
        if (w_hs)
        begin
            wvalid = 1'b0;
            w_done = 1'b1;
        end
        cycles++;
        if (cycles > TIMEOUT_CYCLES)
            abort_run("AXI write address or data handshake");
    end
    cycles = 0;
    while (!bvalid)
    begin
        @(negedge clk);
        cycles++;
        if (cycles > TIMEOUT_CYCLES)
            abort_run("AXI write response");
    end
    if (bresp !== 2'b00)
        report_mismatch("write response", axil_data_t'(bresp), '0);
    @(negedge clk);   // Response taken at the edge just passed
    bready = 1'b0;
endtask

task automatic axil_read(input axil_addr_t addr, output axil_data_t data);
    int cycles;
    cycles = 0;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    while (!arready)
    begin
        @(negedge clk);
        cycles++;
        if (cycles > TIMEOUT_CYCLES)
            abort_run("AXI read address handshake");
    end
    @(negedge clk);
    arvalid = 1'b0;
    cycles  = 0;
    while (!rvalid)
    begin
        @(negedge clk);
        cycles++;
        if (cycles > TIMEOUT_CYCLES)
            abort_run("AXI read data");
    end
    data = rdata;
    if (rresp !== 2'b00)
        report_mismatch("read response", axil_data_t'(rresp), '0);
    @(negedge clk);
    rready = 1'b0;
endtask

// Reference encoder with generators (7,5) or (7,7,5) from state 0
function automatic coded_frame_t encode_ref(input frame_t info, input logic rate);
    coded_frame_t coded;
    logic         prev1;
    logic         prev2;
    logic         u;
    int           pos;
    coded = '0;
    prev1 = 1'b0;
    prev2 = 1'b0;
    pos   = (rate == RATE_THIRD) ? CODED_BITS - 1 : 2 * FRAME_BITS - 1;
    for (int i = FRAME_BITS - 1; i >= 0; i--)
    begin
        u          = info[i];
        coded[pos] = u ^ prev1 ^ prev2;
        if (rate == RATE_THIRD)
        begin
            coded[pos - 1] = u ^ prev1 ^ prev2;
            coded[pos - 2] = u ^ prev2;
            pos = pos - 3;
        end
        else
        begin
            coded[pos - 1] = u ^ prev2;
            pos = pos - 2;
        end
        prev2 = prev1;
        prev1 = u;
    end
    return coded;
endfunction

function automatic frame_t random_frame();
    frame_t f;
    for (int k = 0; k < ENC_WORDS; k++)
        f[32*k +: 32] = $urandom();
    return f;
endfunction

task automatic load_enc_frame(input frame_t f);
    for (int k = 0; k < ENC_WORDS; k++)
        axil_write(axil_addr_t'(REG_ENC_BASE + 4*k), f[32*k +: 32]);
endtask

task automatic load_dec_frame(input coded_frame_t c);
    for (int k = 0; k < CODED_WORDS; k++)
        axil_write(axil_addr_t'(REG_DEC_BASE + 4*k), c[32*k +: 32]);
endtask

task automatic start_run(input logic mode, input logic rate);
    axil_write(REG_CTRL, {29'd0, rate, mode, 1'b1});
endtask

task automatic wait_done();
    axil_data_t status;
    int         polls;
    polls = 0;
    axil_read(REG_STATUS, status);
    while (!status[1])
    begin
        polls++;
        if (polls > POLL_LIMIT)
            abort_run("codec run (done flag)");
        axil_read(REG_STATUS, status);
    end
    if (status !== 32'h2)
        report_mismatch("STATUS after done", status, 32'h2);
endtask

task automatic read_result(output coded_frame_t r);
    axil_data_t word;
    for (int k = 0; k < CODED_WORDS; k++)
    begin
        axil_read(axil_addr_t'(REG_RES_BASE + 4*k), word);
        r[32*k +: 32] = word;
    end
endtask

// Expects the decoded frame in words 0 to 3 and zero above
task automatic decode_and_check(input logic rate, input int flip_pos);
    frame_t       info;
    coded_frame_t coded;
    coded_frame_t res;
    coded_frame_t expect_res;
    info  = random_frame();
    coded = encode_ref(info, rate);
    if (flip_pos >= 0)
        coded[flip_pos] = ~coded[flip_pos];
    load_dec_frame(coded);
    start_run(MODE_DECODE, rate);
    wait_done();
    read_result(res);
    expect_res = coded_frame_t'(info);
    for (int k = 0; k < CODED_WORDS; k++)
    begin
        if (res[32*k +: 32] !== expect_res[32*k +: 32])
            report_mismatch($sformatf("decoded word %0d", k), res[32*k +: 32],
                            expect_res[32*k +: 32]);
    end
endtask

task automatic reset_register_access();
    axil_addr_t unmapped [4] = '{8'h08, 8'h0C, 8'h80, 8'hFC};
    frame_t     f;
    axil_data_t word;
    begin_test();
    axil_read(REG_STATUS, word);
    if (word !== 32'h0)
        report_mismatch("STATUS after reset", word, 32'h0);
    f = random_frame();
    load_enc_frame(f);
    for (int k = 0; k < ENC_WORDS; k++)
    begin
        axil_read(axil_addr_t'(REG_ENC_BASE + 4*k), word);
        if (word !== f[32*k +: 32])
            report_mismatch($sformatf("encoder frame word %0d", k), word, f[32*k +: 32]);
    end
    for (int i = 0; i < 4; i++)
    begin
        axil_read(unmapped[i], word);
        if (word !== 32'h0)
            report_mismatch($sformatf("unmapped address %h", unmapped[i]), word, 32'h0);
    end
    end_test("Reset and register access");
endtask

task automatic encode_and_check(input logic rate, input string name);
    frame_t       info;
    coded_frame_t res;
    coded_frame_t expect_res;
    begin_test();
    info = random_frame();
    load_enc_frame(info);
    start_run(MODE_ENCODE, rate);
    wait_done();
    read_result(res);
    expect_res = encode_ref(info, rate);   // Upper words stay zero at rate 1/2
    for (int k = 0; k < CODED_WORDS; k++)
    begin
        if (res[32*k +: 32] !== expect_res[32*k +: 32])
            report_mismatch($sformatf("coded word %0d", k), res[32*k +: 32],
                            expect_res[32*k +: 32]);
    end
    end_test(name);
endtask

task automatic clean_decode();
    begin_test();
    decode_and_check(RATE_HALF, -1);
    decode_and_check(RATE_THIRD, -1);
    end_test("Clean decode, both rates");
endtask

task automatic single_error_decode();
    begin_test();
    decode_and_check(RATE_HALF, 131);
    decode_and_check(RATE_THIRD, 190);
    end_test("Single-error correction");
endtask

task automatic busy_protection();
    frame_t       info;
    coded_frame_t res;
    coded_frame_t expect_res;
    axil_data_t   enc_word0;
    axil_data_t   word;
    begin_test();
    info = random_frame();
    load_dec_frame(encode_ref(info, RATE_HALF));
    axil_read(REG_ENC_BASE, enc_word0);
    start_run(MODE_DECODE, RATE_HALF);
    axil_read(REG_STATUS, word);
    if (word !== 32'h1)
        report_mismatch("STATUS while running", word, 32'h1);
    start_run(MODE_ENCODE, RATE_THIRD);    // Must be dropped while busy
    axil_write(REG_ENC_BASE, ~enc_word0);
    wait_done();
    read_result(res);
    expect_res = coded_frame_t'(info);
    for (int k = 0; k < CODED_WORDS; k++)
    begin
        if (res[32*k +: 32] !== expect_res[32*k +: 32])
            report_mismatch($sformatf("result word %0d", k), res[32*k +: 32],
                            expect_res[32*k +: 32]);
    end
    axil_read(REG_ENC_BASE, word);
    if (word !== enc_word0)
        report_mismatch("encoder frame word 0", word, enc_word0);
    axil_read(REG_CTRL, word);
    if (word !== 32'h2)
        report_mismatch("CTRL after ignored start", word, 32'h2);
    end_test("Busy protection");
endtask

initial
begin
    void'($urandom(83366));
    errors        = 0;
    err_at_start  = 0;
    tests_run     = 0;
    tests_failing = 0;
    rst     = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;

    reset_register_access();
    encode_and_check(RATE_HALF, "Rate-1/2 encode");
    encode_and_check(RATE_THIRD, "Rate-1/3 encode");
    clean_decode();
    single_error_decode();
    busy_protection();

    $display("Tests run: %0d, tests with errors: %0d, errors: %0d",
             tests_run, tests_failing, errors);
    if (errors == 0)
        $display("Testbench passed");
    else
        $display("Testbench failed");
    $finish;
end

endmodule

// File: conv_codec.f
codec_pkg.sv
axil_regs.sv
frame_slicer.sv
conv_encoder.sv
viterbi_decoder.sv
conv_codec.sv
tb_conv_codec.sv
